// File: bench/strobe_unit_properties.sv
`timescale 1ns/10ps

module strobe_unit_properties (
	input logic                      clk_i,
	input logic                      arstn_i,
	input logic                      err_o,
	input logic                      rdy_o,
	input logic                      stb_o,
	input logic                      stb_valid_o,
	input strobe_types_pkg::period_t stb_period_o
);

	// a measurement either succeeds or fails
	a_rdy_err: assert property (@(posedge clk_i) disable iff (!arstn_i)
		!(rdy_o && err_o)) else $error("rdy_o and err_o high together");

	a_valid_rdy: assert property (@(posedge clk_i) disable iff (!arstn_i)
		stb_valid_o |-> rdy_o) else $error("stb_valid_o high without rdy_o");

	a_period_stable: assert property (@(posedge clk_i) disable iff (!arstn_i)
		rdy_o && $past(rdy_o) |-> $stable(stb_period_o))
		else $error("stb_period_o changed while rdy_o high");

	// strobe low lasts a single cycle
	a_one_low: assert property (@(posedge clk_i) disable iff (!arstn_i)
		rdy_o && !stb_o |=> stb_o) else $error("stb_o low for two cycles");

endmodule

bind strobe_unit strobe_unit_properties u_properties (
	.clk_i, .arstn_i, .err_o, .rdy_o, .stb_o, .stb_valid_o, .stb_period_o
);

// File: bench/strobe_unit_tb.sv
`timescale 1ns/10ps

module strobe_unit_tb;

	typedef struct packed {
		logic [31:0] half;	// sig_i half-period in cycles
		logic [31:0] n_req;	// requests after the first pulse
		logic        exp_err;
	} row_t;

	localparam int N_ROWS = 4;
	localparam row_t ROWS [N_ROWS] = '{
		'{32'd3, 32'd0, 1'b1},
		'{32'd10, 32'd3, 1'b0},
		'{32'd37, 32'd2, 1'b0},
		'{32'd150, 32'd2, 1'b0}
	};
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic                      clk_i, arstn_i, sig_i, stb_req_i;
	logic                      err_o, rdy_o, stb_o, stb_valid_o;
	strobe_types_pkg::period_t stb_period_o;
	logic [31:0]               lfsr_q = 32'h8151;
	logic                      sig_run = 1'b0;
	int unsigned               cyc = 0;
	int unsigned               half_q = 1;
	int unsigned               per = 2;
	int unsigned               first_low = 0;
	int unsigned               err_cnt = 0;

	strobe_unit UUT (
		.clk_i, .arstn_i, .sig_i, .stb_req_i,
		.err_o, .rdy_o, .stb_o, .stb_valid_o, .stb_period_o
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i)
		cyc <= cyc + 1;

	// square wave on sig_i, restarts low on reset
	initial begin : sig_gen
		int unsigned n;
		n = 0;
		sig_i = 1'b0;
		forever begin
			@(negedge clk_i);
			n++;
			if (!sig_run) begin
				sig_i = 1'b0;
				n = 0;
			end else if (n >= half_q) begin
				sig_i = ~sig_i;
				n = 0;
			end
		end
	end

	// --------------------
	// helpers
	// --------------------
	task automatic abort_run(input string why);
		err_cnt++;
		$display("ERROR: %s at cycle %0d", why, cyc);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "simulation stopped");
		end
	endtask

	task automatic check_outs(input logic rdy, input logic err, input logic stb,
			input logic vld);
		check_val("rdy_o", 32'(rdy_o), 32'(rdy));
		check_val("err_o", 32'(err_o), 32'(err));
		check_val("stb_o", 32'(stb_o), 32'(stb));
		check_val("stb_valid_o", 32'(stb_valid_o), 32'(vld));
	endtask

	// galois lfsr, one step per bit
	function automatic int unsigned rand_bits(input int n);
		int unsigned val;
		int          k;
		val = 0;
		for (k = 0; k < n; k++) begin
			val = {val[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
		end
		return val;
	endfunction

	task automatic apply_reset();
		@(negedge clk_i);
		sig_run = 1'b0;
		stb_req_i = 1'b0;
		arstn_i = 1'b0;
		repeat (3) @(negedge clk_i);
		arstn_i = 1'b1;
		sig_run = 1'b1;
	endtask

	task automatic wait_result(input logic exp_err);
		int unsigned n;
		n = 0;
		while ((exp_err ? err_o : rdy_o) !== 1'b1) begin
			if (n == 8 * per + 20)
				abort_run("measurement never finished");
			n++;
			@(negedge clk_i);
		end
	endtask

	task automatic wait_low(output int unsigned at);
		int unsigned n;
		n = 0;
		while (stb_o !== 1'b0) begin
			if (n == 3 * per + 20)
				abort_run("no low cycle on stb_o after rdy_o");
			n++;
			@(negedge clk_i);
		end
		at = cyc;
	endtask

	// one request pulse, then one low cycle on the grid
	task automatic request_strobe();
		int unsigned lows, low_at, n;
		lows = 0;
		low_at = first_low;
		n = 0;
		stb_req_i = 1'b1;
		@(negedge clk_i);
		stb_req_i = 1'b0;
		check_val("stb_valid_o", 32'(stb_valid_o), 32'd0);
		while (stb_valid_o !== 1'b1) begin
			if (stb_o === 1'b0) begin
				lows++;
				low_at = cyc;
			end
			if (n == 2 * per + 20)
				abort_run("stb_valid_o did not return after a request");
			n++;
			@(negedge clk_i);
		end
		check_val("stb_o", 32'(stb_o), 32'd1);
		check_val("stb_o low cycles", lows, 32'd1);
		check_val("stb_o grid offset", (low_at - first_low) % per, 32'd0);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin : main_seq
		int unsigned r, k;
		arstn_i = 1'b0;
		stb_req_i = 1'b0;
		for (r = 0; r < N_ROWS; r++) begin
			half_q = ROWS[r].half;
			per = 2 * half_q;
			apply_reset();
			repeat (4 * half_q) begin	// ends well before the third edge
				check_outs(1'b0, 1'b0, 1'b0, 1'b0);
				@(negedge clk_i);
			end
			wait_result(ROWS[r].exp_err);
			if (ROWS[r].exp_err) begin
				repeat (4 * per) begin
					check_outs(1'b0, 1'b1, 1'b0, 1'b0);
					@(negedge clk_i);
				end
			end else begin
				check_val("stb_period_o", stb_period_o, per);
				check_outs(1'b1, 1'b0, 1'b1, 1'b0);
				wait_low(first_low);	// free pulse after reset
				check_val("stb_valid_o", 32'(stb_valid_o), 32'd0);
				@(negedge clk_i);
				repeat (2 * per) begin
					check_outs(1'b1, 1'b0, 1'b1, 1'b1);
					@(negedge clk_i);
				end
				for (k = 0; k < ROWS[r].n_req; k++) begin
					repeat (per + rand_bits(12) % (2 * per + 1)) @(negedge clk_i);
					request_strobe();
				end
			end
		end
		if (err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// five periods per step of a row, plus slack
	initial begin : watchdog
		int unsigned budget, i;
		budget = 500;
		for (i = 0; i < N_ROWS; i++)
			budget += (4 + ROWS[i].n_req + 2) * 5 * 2 * ROWS[i].half;
		repeat (budget) @(posedge clk_i);
		abort_run("watchdog timeout, tests did not complete in time");
	end

endmodule

// File: project.f
verilog/strobe_cfg_pkg.sv
verilog/strobe_types_pkg.sv
verilog/sig_sync.sv
verilog/split_counter.sv
verilog/period_meter.sv
verilog/two_cycle_adder.sv
verilog/strobe_timer.sv
verilog/strobe_unit.sv
bench/strobe_unit_properties.sv
bench/strobe_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the strobe_unit testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module strobe_unit_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/Vstrobe_unit_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

// File: verilog/period_meter.sv
`timescale 1ns/10ps

module period_meter (
	input  logic                          clk_i,
	input  logic                          arstn_i,
	input  logic                          edge_i,
	input  strobe_types_pkg::tstamp_t     t_cnt_i,
	output strobe_types_pkg::period_meas_t meas_o,
	output logic                          err_o
);

	strobe_types_pkg::meter_state_t state_q;
	strobe_types_pkg::meter_state_t state_d;
	strobe_types_pkg::tstamp_t      t_start_q;
	strobe_types_pkg::tstamp_t      t_end_q;
	strobe_types_pkg::period_t      diff;
	logic                           too_short;

	assign diff      = t_end_q - t_start_q;
	assign too_short = diff < strobe_types_pkg::period_t'(strobe_cfg_pkg::MIN_PERIOD);

	// first edge only aligns, second and third are timestamped
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			strobe_types_pkg::FIND_EDGE_1: begin
				if (edge_i)
					state_d = strobe_types_pkg::FIND_EDGE_2;
			end
			strobe_types_pkg::FIND_EDGE_2: begin
				if (edge_i)
					state_d = strobe_types_pkg::WRITE_START;
			end
			strobe_types_pkg::WRITE_START: state_d = strobe_types_pkg::FIND_EDGE_3;
			strobe_types_pkg::FIND_EDGE_3: begin
				if (edge_i)
					state_d = strobe_types_pkg::WRITE_END;
			end
			strobe_types_pkg::WRITE_END: state_d = strobe_types_pkg::CHECK_PERIOD;
			strobe_types_pkg::CHECK_PERIOD: begin
				if (too_short)
					state_d = strobe_types_pkg::FIND_EDGE_1;	// start over
				else
					state_d = strobe_types_pkg::DONE;
			end
			strobe_types_pkg::DONE: state_d = strobe_types_pkg::DONE;	// held until reset
			default: state_d = strobe_types_pkg::FIND_EDGE_1;
		endcase
	end

	// timestamps, both one cycle after their edge
	always_ff @(posedge clk_i) begin
		if (state_q == strobe_types_pkg::WRITE_START)
			t_start_q <= t_cnt_i;
		if (state_q == strobe_types_pkg::WRITE_END)
			t_end_q <= t_cnt_i;
	end

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			state_q <= strobe_types_pkg::FIND_EDGE_1;
			meas_o  <= '0;
			err_o   <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == strobe_types_pkg::CHECK_PERIOD) begin
				if (too_short) begin
					err_o <= 1'b1;
				end else begin
					meas_o.period <= diff;
					meas_o.done   <= 1'b1;
					err_o         <= 1'b0;	// a good retry clears it
				end
			end
		end
	end

endmodule

// File: verilog/sig_sync.sv
`timescale 1ns/10ps

module sig_sync (
	input  logic clk_i,
	input  logic arstn_i,
	input  logic sig_i,
	output logic edge_o
);

	logic [strobe_cfg_pkg::SYNC_STAGES-1:0] sync_q;	// sig_i enters at bit 0
	logic                                   prev_q;
	logic                                   sync_bit;

	assign sync_bit = sync_q[strobe_cfg_pkg::SYNC_STAGES-1];

	// synchronizer chain and registered edge detect
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			sync_q <= '0;
			prev_q <= 1'b0;
			edge_o <= 1'b0;
		end else begin
			sync_q <= {sync_q[strobe_cfg_pkg::SYNC_STAGES-2:0], sig_i};
			prev_q <= sync_bit;
			edge_o <= sync_bit & ~prev_q;	// one cycle per rising edge
		end
	end

endmodule

// File: verilog/split_counter.sv
`timescale 1ns/10ps

module split_counter (
	input  logic                     clk_i,
	input  logic                     arstn_i,
	output strobe_types_pkg::tstamp_t t_cnt_o
);

	strobe_types_pkg::half_t low_q;
	strobe_types_pkg::half_t low_dly_q;	// low half, aligned to high_q
	strobe_types_pkg::half_t high_q;
	strobe_types_pkg::half_t low_next;
	logic                    carry;
	logic                    carry_q;

	assign {carry, low_next} = {1'b0, low_q} + {{strobe_cfg_pkg::HALF_WIDTH{1'b0}}, 1'b1};

	// --------------------
	// low half
	// --------------------
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			low_q     <= '0;
			low_dly_q <= '0;
			carry_q   <= 1'b0;
		end else begin
			low_q     <= low_next;
			low_dly_q <= low_q;
			carry_q   <= carry;	// wraps into high half next cycle
		end
	end

	// --------------------
	// high half and output
	// --------------------
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			high_q  <= '0;
			t_cnt_o <= '0;
		end else begin
			high_q  <= high_q + strobe_types_pkg::half_t'(carry_q);
			t_cnt_o <= {high_q, low_dly_q};
		end
	end

endmodule

// File: verilog/strobe_cfg_pkg.sv
package strobe_cfg_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int T_CNT_WIDTH = 32;	// timestamp width
	localparam int HALF_WIDTH  = T_CNT_WIDTH / 2;	// split counter / split compare
	localparam int SYNC_STAGES = 2;

	// --------------------
	// strobe timing
	// --------------------
	localparam int ZERO_HOLD_CYCLES = 1;	// low cycles per strobe
	localparam int PIPE_COMP        = 3;	// adder latch + two compare stages
	localparam int FIRST_OFFSET     = 6;	// first period shortened by this much

	// below this the compare pipeline cannot keep up
	localparam int MIN_PERIOD = 8;

endpackage

// File: verilog/strobe_timer.sv
`timescale 1ns/10ps

module strobe_timer (
	input  logic                          clk_i,
	input  logic                          arstn_i,
	input  strobe_types_pkg::tstamp_t     t_cnt_i,
	input  strobe_types_pkg::period_meas_t meas_i,
	input  logic                          stb_req_i,
	output logic                          stb_o,
	output logic                          stb_valid_o
);

	strobe_types_pkg::timer_state_t state_q, state_d;
	strobe_types_pkg::period_t      end_off_q, hold_off_q, first_cut;
	strobe_types_pkg::tstamp_t      end_sum, hold_sum;
	strobe_types_pkg::tstamp_t      end_q, hold_q;	// scheduled counter values
	strobe_types_pkg::half_t        t_lo, t_hi, end_lo, end_hi, hold_lo, hold_hi;
	logic end_valid, hold_valid;
	logic end_lo_q, end_hi_q, hold_lo_q, hold_hi_q;
	logic is_end_q, is_hold_q;
	logic first_q, shorten, sched, armed;
	logic int_stb_q, stb_oe_q;	// oe high forces stb_o high
	logic req_q, req_rise;

	assign sched    = (state_q == strobe_types_pkg::SCHEDULE);
	assign armed    = (state_q == strobe_types_pkg::WAIT_END);
	assign req_rise = stb_req_i & ~req_q;

	// --------------------
	// offsets and adders
	// --------------------
	// short periods skip the first cut so the target stays ahead of the counter
	assign shorten = first_q & (meas_i.period >= strobe_types_pkg::period_t'(
		strobe_cfg_pkg::MIN_PERIOD + strobe_cfg_pkg::FIRST_OFFSET));
	assign first_cut = shorten ? strobe_types_pkg::period_t'(strobe_cfg_pkg::FIRST_OFFSET) : '0;

	always_ff @(posedge clk_i) begin
		end_off_q  <= meas_i.period - strobe_types_pkg::period_t'(strobe_cfg_pkg::PIPE_COMP)
			- first_cut;
		hold_off_q <= meas_i.period - strobe_types_pkg::period_t'(
			strobe_cfg_pkg::ZERO_HOLD_CYCLES + strobe_cfg_pkg::PIPE_COMP) - first_cut;
		if (end_valid)
			end_q <= end_sum;
		if (hold_valid)
			hold_q <= hold_sum;
	end

	two_cycle_adder adder_hold (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.a_i     (t_cnt_i),
		.b_i     (hold_off_q),
		.valid_i (sched),
		.res_o   (hold_sum),
		.valid_o (hold_valid)
	);

	two_cycle_adder adder_end (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.a_i     (t_cnt_i),
		.b_i     (end_off_q),
		.valid_i (sched),
		.res_o   (end_sum),
		.valid_o (end_valid)
	);

	// --------------------
	// split compare
	// --------------------
	assign {t_hi, t_lo}       = t_cnt_i;
	assign {end_hi, end_lo}   = end_q;
	assign {hold_hi, hold_lo} = hold_q;

	always_ff @(posedge clk_i) begin
		end_lo_q  <= (t_lo == end_lo);
		end_hi_q  <= (t_hi == end_hi);
		hold_lo_q <= (t_lo == hold_lo);
		hold_hi_q <= (t_hi == hold_hi);
	end

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			strobe_types_pkg::IDLE: begin
				if (meas_i.done)
					state_d = strobe_types_pkg::SCHEDULE;
			end
			strobe_types_pkg::SCHEDULE: state_d = strobe_types_pkg::WAIT_ADD;
			strobe_types_pkg::WAIT_ADD: begin
				if (end_valid)
					state_d = strobe_types_pkg::ARM;
			end
			strobe_types_pkg::ARM: state_d = strobe_types_pkg::WAIT_END;
			strobe_types_pkg::WAIT_END: begin
				if (is_end_q)
					state_d = strobe_types_pkg::SCHEDULE;	// next grid point
			end
			default: state_d = strobe_types_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			state_q   <= strobe_types_pkg::IDLE;
			first_q   <= 1'b1;
			is_end_q  <= 1'b0;
			is_hold_q <= 1'b0;
			int_stb_q <= 1'b1;
			stb_oe_q  <= 1'b0;	// first pulse goes out without a request
			req_q     <= 1'b0;
		end else begin
			state_q   <= state_d;
			req_q     <= stb_req_i;
			is_end_q  <= armed & end_lo_q & end_hi_q;
			is_hold_q <= armed & hold_lo_q & hold_hi_q;
			if (sched)
				first_q <= 1'b0;
			if (is_hold_q)
				int_stb_q <= 1'b0;
			else if (is_end_q)
				int_stb_q <= 1'b1;
			if (req_rise)
				stb_oe_q <= 1'b0;	// request wins over strobe end
			else if (is_end_q)
				stb_oe_q <= 1'b1;
		end
	end

	// oe is only ever set by a strobe end, which needs a finished measurement
	assign stb_o       = meas_i.done & (int_stb_q | stb_oe_q);
	assign stb_valid_o = stb_oe_q;

endmodule

// File: verilog/strobe_types_pkg.sv
package strobe_types_pkg;

	// counter value and period in cycles
	typedef logic [strobe_cfg_pkg::T_CNT_WIDTH-1:0] tstamp_t;
	typedef logic [strobe_cfg_pkg::T_CNT_WIDTH-1:0] period_t;
	typedef logic [strobe_cfg_pkg::HALF_WIDTH-1:0]  half_t;	// one counter half

	// --------------------
	// state machines
	// --------------------
	typedef enum logic [6:0] {
		FIND_EDGE_1  = 7'b0000001,
		FIND_EDGE_2  = 7'b0000010,
		WRITE_START  = 7'b0000100,
		FIND_EDGE_3  = 7'b0001000,
		WRITE_END    = 7'b0010000,
		CHECK_PERIOD = 7'b0100000,
		DONE         = 7'b1000000
	} meter_state_t;

	typedef enum logic [2:0] {
		IDLE,
		SCHEDULE,
		WAIT_ADD,
		ARM,
		WAIT_END
	} timer_state_t;

	// measurement result, period valid while done is high
	typedef struct packed {
		period_t period;
		logic    done;
	} period_meas_t;

endpackage

// File: verilog/strobe_unit.sv
`timescale 1ns/10ps

module strobe_unit (
	input  logic                      clk_i,
	input  logic                      arstn_i,
	input  logic                      sig_i,
	input  logic                      stb_req_i,
	output logic                      err_o,
	output logic                      rdy_o,
	output logic                      stb_o,
	output logic                      stb_valid_o,
	output strobe_types_pkg::period_t stb_period_o
);

	logic                           sig_edge;
	strobe_types_pkg::tstamp_t      t_cnt;
	strobe_types_pkg::period_meas_t meas;

	sig_sync u_sig_sync (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.sig_i   (sig_i),
		.edge_o  (sig_edge)
	);

	split_counter u_split_counter (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.t_cnt_o (t_cnt)
	);

	period_meter u_period_meter (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.edge_i  (sig_edge),
		.t_cnt_i (t_cnt),
		.meas_o  (meas),
		.err_o   (err_o)
	);

	strobe_timer u_strobe_timer (
		.clk_i       (clk_i),
		.arstn_i     (arstn_i),
		.t_cnt_i     (t_cnt),
		.meas_i      (meas),
		.stb_req_i   (stb_req_i),
		.stb_o       (stb_o),
		.stb_valid_o (stb_valid_o)
	);

	assign rdy_o        = meas.done;	// measured once per reset
	assign stb_period_o = meas.period;

endmodule

// File: verilog/two_cycle_adder.sv
`timescale 1ns/10ps

module two_cycle_adder (
	input  logic                      clk_i,
	input  logic                      arstn_i,
	input  strobe_types_pkg::tstamp_t a_i,
	input  strobe_types_pkg::tstamp_t b_i,
	input  logic                      valid_i,
	output strobe_types_pkg::tstamp_t res_o,
	output logic                      valid_o
);

	strobe_types_pkg::half_t a_lo, a_hi, b_lo, b_hi;
	strobe_types_pkg::half_t lo_sum_q, lo_dly_q;
	strobe_types_pkg::half_t a_hi_q, b_hi_q, hi_sum_q;
	logic [strobe_cfg_pkg::HALF_WIDTH:0] lo_full;	// with carry out
	logic carry_q;
	logic valid_q;

	assign {a_hi, a_lo} = a_i;
	assign {b_hi, b_lo} = b_i;
	assign lo_full      = {1'b0, a_lo} + {1'b0, b_lo};

	always_ff @(posedge clk_i) begin
		// stage one
		lo_sum_q <= lo_full[strobe_cfg_pkg::HALF_WIDTH-1:0];
		carry_q  <= lo_full[strobe_cfg_pkg::HALF_WIDTH];
		a_hi_q   <= a_hi;
		b_hi_q   <= b_hi;
		// stage two
		hi_sum_q <= a_hi_q + b_hi_q + strobe_types_pkg::half_t'(carry_q);
		lo_dly_q <= lo_sum_q;
	end

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			valid_q <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_q <= valid_i;
			valid_o <= valid_q;
		end
	end

	assign res_o = {hi_sum_q, lo_dly_q};

endmodule
